// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ts_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

# build and run, success only if the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== project.f ====
rtl/ts_pkg.sv
rtl/ts_mem.sv
rtl/ts_mem_arb.sv
rtl/ts_sprite_scan.sv
rtl/ts_tile_scan.sv
rtl/ts_layer_seq.sv
rtl/ts_top.sv
verif/ts_tb.sv

// ==== rtl/ts_layer_seq.sv ====
// per-line layer sequencer, starts each enabled scanner in order and routes its jobs out
`default_nettype none
`timescale 1ns/100ps

module ts_layer_seq import ts_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  logic [7:0]  ts_conf,
	output logic        ts_busy,
	output logic        spr_go,
	output logic [5:0]  spr_first,
	input  logic        spr_fin,
	input  logic [5:0]  spr_next,
	output logic        tile_go,
	output logic        tile_layer,
	input  logic        tile_fin,
	input  logic        spr_job_req,
	output logic        spr_job_done,
	input  logic [8:0]  spr_job_x,
	input  logic [2:0]  spr_job_xs,
	input  logic        spr_job_xf,
	input  logic [11:0] spr_job_tnum,
	input  logic [5:0]  spr_job_row,
	input  logic [3:0]  spr_job_pal,
	input  logic        tile_job_req,
	output logic        tile_job_done,
	input  logic [8:0]  tile_job_x,
	input  logic [2:0]  tile_job_xs,
	input  logic        tile_job_xf,
	input  logic [11:0] tile_job_tnum,
	input  logic [5:0]  tile_job_row,
	input  logic [3:0]  tile_job_pal,
	output logic        tsr_go,
	input  logic        tsr_done,
	output logic [8:0]  tsr_x,
	output logic [2:0]  tsr_xs,
	output logic        tsr_xf,
	output logic [11:0] tsr_tnum,
	output logic [5:0]  tsr_row,
	output logic [3:0]  tsr_pal
);

	ts_layer_e  layer, nxt;
	logic       go_q;
	logic       launched;
	logic [5:0] spr_idx;
	logic       s_en, t0_en, t1_en;
	logic       is_spr, is_tile;
	logic       fin;

	assign s_en = ts_conf[CONF_SPR];
	assign t0_en = ts_conf[CONF_T0];
	assign t1_en = ts_conf[CONF_T1];
	assign is_spr = (layer == S0) || (layer == S1) || (layer == S2);
	assign is_tile = (layer == T0) || (layer == T1);
	assign fin = is_spr ? spr_fin : tile_fin;

	assign ts_busy = layer != L_END;
	assign spr_go = go_q && is_spr;
	assign tile_go = go_q && is_tile;
	assign tile_layer = layer == T1;
	assign spr_first = spr_idx;

	// fall through to the next enabled layer
	always_comb
	begin
		case (layer)
			L_BEG: nxt = s_en ? S0 : t0_en ? T0 : t1_en ? T1 : L_END;
			S0: nxt = t0_en ? T0 : s_en ? S1 : t1_en ? T1 : L_END;
			T0: nxt = s_en ? S1 : t1_en ? T1 : L_END;
			S1: nxt = t1_en ? T1 : s_en ? S2 : L_END;
			T1: nxt = s_en ? S2 : L_END;
			default: nxt = L_END;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			layer    <= L_END;
			go_q     <= 1'b0;
			launched <= 1'b0;
			spr_idx  <= '0;
		end
		else if (layer == L_END)
		begin
			if (start)
			begin
				layer   <= L_BEG;
				spr_idx <= '0;
			end
		end
		else if (layer == L_BEG)
			layer <= nxt;
		else if (!launched)
		begin
			go_q     <= 1'b1;
			launched <= 1'b1;
		end
		else if (go_q)
		begin
			if (fin)
			begin
				go_q <= 1'b0;
				// next sprite layer resumes where this one stopped
				if (is_spr)
					spr_idx <= spr_next;
			end
		end
		else if (!fin)
		begin
			launched <= 1'b0;
			layer    <= nxt;
		end
	end

	// only the active layer's scanner reaches the renderer
	assign tsr_go = is_spr ? spr_job_req : (is_tile && tile_job_req);
	assign spr_job_done = is_spr && tsr_done;
	assign tile_job_done = is_tile && tsr_done;
	assign tsr_x = is_spr ? spr_job_x : tile_job_x;
	assign tsr_xs = is_spr ? spr_job_xs : tile_job_xs;
	assign tsr_xf = is_spr ? spr_job_xf : tile_job_xf;
	assign tsr_tnum = is_spr ? spr_job_tnum : tile_job_tnum;
	assign tsr_row = is_spr ? spr_job_row : tile_job_row;
	assign tsr_pal = is_spr ? spr_job_pal : tile_job_pal;

	// a pending render job keeps its payload until the renderer answers
	a_tsr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		tsr_go && !tsr_done |=> tsr_go
			&& $stable({tsr_x, tsr_xs, tsr_xf, tsr_tnum, tsr_row, tsr_pal}));

endmodule

`default_nettype wire

// ==== rtl/ts_mem.sv ====
// single-port descriptor and tile-map RAM, one write or registered read per cycle
`default_nettype none
`timescale 1ns/100ps

module ts_mem import ts_pkg::*;
(
	input  logic              clk,
	input  logic              we,
	input  logic [MEM_AW-1:0] addr,
	input  logic [MEM_DW-1:0] wdata,
	output logic [MEM_DW-1:0] rdata
);

	logic [MEM_DW-1:0] mem [0:(1 << MEM_AW) - 1];

	// read data shows up the cycle after the address
	always_ff @(posedge clk)
	begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// ==== rtl/ts_mem_arb.sv ====
// fixed-priority arbiter sharing ts_mem between the CPU writer and both scanners
`default_nettype none
`timescale 1ns/100ps

module ts_mem_arb import ts_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              cpu_req,
	output logic              cpu_ack,
	input  logic [MEM_AW-1:0] cpu_addr,
	input  logic [MEM_DW-1:0] cpu_wdata,
	input  logic              spr_req,
	output logic              spr_ack,
	input  logic [MEM_AW-1:0] spr_addr,
	output logic [MEM_DW-1:0] spr_rdata,
	input  logic              tile_req,
	output logic              tile_ack,
	input  logic [MEM_AW-1:0] tile_addr,
	output logic [MEM_DW-1:0] tile_rdata,
	output logic              mem_we,
	output logic [MEM_AW-1:0] mem_addr,
	output logic [MEM_DW-1:0] mem_wdata,
	input  logic [MEM_DW-1:0] mem_rdata
);

	arb_owner_e        owner;
	logic              cnt;
	logic              own_req;
	logic              own_ack;
	logic [MEM_DW-1:0] rd_q;

	always_comb
	begin
		case (owner)
			OWN_SPR:
			begin
				own_req  = spr_req;
				mem_addr = spr_addr;
			end
			OWN_TILE:
			begin
				own_req  = tile_req;
				mem_addr = tile_addr;
			end
			OWN_CPU:
			begin
				own_req  = cpu_req;
				mem_addr = cpu_addr;
			end
			default:
			begin
				own_req  = 1'b0;
				mem_addr = cpu_addr;
			end
		endcase
	end

	assign own_ack = cpu_ack | spr_ack | tile_ack;
	// single write in the first owned cycle
	assign mem_we = (owner == OWN_CPU) && !cnt && !own_ack;
	assign mem_wdata = cpu_wdata;
	assign spr_rdata = rd_q;
	assign tile_rdata = rd_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			owner    <= OWN_NONE;
			cnt      <= 1'b0;
			cpu_ack  <= 1'b0;
			spr_ack  <= 1'b0;
			tile_ack <= 1'b0;
		end
		else if (owner == OWN_NONE)
		begin
			cnt <= 1'b0;
			if (cpu_req)
				owner <= OWN_CPU;
			else if (spr_req)
				owner <= OWN_SPR;
			else if (tile_req)
				owner <= OWN_TILE;
		end
		else if (!own_ack)
		begin
			// second owned cycle sees the registered read
			if (cnt)
			begin
				cpu_ack  <= owner == OWN_CPU;
				spr_ack  <= owner == OWN_SPR;
				tile_ack <= owner == OWN_TILE;
			end
			cnt <= 1'b1;
		end
		else if (!own_req)
		begin
			cpu_ack  <= 1'b0;
			spr_ack  <= 1'b0;
			tile_ack <= 1'b0;
			owner    <= OWN_NONE;
		end
	end

	// held for the owner until its ack falls
	always_ff @(posedge clk)
	begin
		if (owner != OWN_NONE && !own_ack && cnt)
			rd_q <= mem_rdata;
	end

	// the owner keeps its request and address steady until acked
	a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		own_req && !own_ack |=> own_ack
			|| (own_req && $stable(mem_addr)));

endmodule

`default_nettype wire

// ==== rtl/ts_pkg.sv ====
// shared sizes, memory map, descriptor fields and enums, imported by every scanner file
`default_nettype none

package ts_pkg;

	// descriptor memory geometry
	localparam int MEM_AW = 8;
	localparam int MEM_DW = 16;

	// sprite descriptors occupy the low words
	localparam int NUM_SPRITES = 42;
	localparam int SPR_WORDS = 3;

	// tile maps, one block of 64 words per tile layer
	localparam int TMAP_BASE = 128;
	localparam int TMAP_WORDS = 64;
	localparam int MAX_TILES = 46;
	localparam int TILE_PX = 8;

	// descriptor bit positions, shared by R0 and R1 where they line up
	localparam int F_CRD_MSB = 8;
	localparam int F_SZ_LSB = 9;
	localparam int F_SZ_MSB = 11;
	localparam int F_ACT = 13;
	localparam int F_LEAP = 14;
	localparam int F_FLIP = 15;

	// R2 and tile-map word layout
	localparam int F_TNUM_MSB = 11;
	localparam int F_PAL_LSB = 12;

	// ts_conf enables
	localparam int CONF_SPR = 7;
	localparam int CONF_T1 = 6;
	localparam int CONF_T0 = 5;

	typedef enum logic [2:0] {S0, T0, S1, T1, S2, L_END, L_BEG} ts_layer_e;

	typedef enum logic [1:0] {R0, R1, R2} spr_word_e;

	typedef enum logic [1:0] {OWN_NONE, OWN_CPU, OWN_SPR, OWN_TILE} arb_owner_e;

endpackage

`default_nettype wire

// ==== rtl/ts_sprite_scan.sv ====
// sprite layer scanner, fetches descriptors from the resume index and sends a job per line hit
`default_nettype none
`timescale 1ns/100ps

module ts_sprite_scan import ts_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [8:0]        line,
	input  logic              spr_go,
	input  logic [5:0]        spr_first,
	output logic              spr_fin,
	output logic [5:0]        spr_next,
	output logic              mem_req,
	input  logic              mem_ack,
	output logic [MEM_AW-1:0] mem_addr,
	input  logic [MEM_DW-1:0] mem_rdata,
	output logic              job_req,
	input  logic              job_done,
	output logic [8:0]        job_x,
	output logic [2:0]        job_xs,
	output logic              job_xf,
	output logic [11:0]       job_tnum,
	output logic [5:0]        job_row,
	output logic [3:0]        job_pal
);

	typedef enum logic [2:0] {SP_IDLE, SP_MREQ, SP_MREL, SP_JOB, SP_JREL, SP_NEXT, SP_FIN}
		sp_state_e;

	sp_state_e         state;
	spr_word_e         word;
	logic [5:0]        idx;
	logic [MEM_DW-1:0] r0_q, r1_q, r2_q;
	logic [6:0]        x_len, y_len;
	logic [9:0]        y_top, y_end;
	logic [5:0]        y_ofs;
	logic              hit;
	logic              last;

	assign mem_req = state == SP_MREQ;
	assign job_req = state == SP_JOB;
	assign spr_fin = state == SP_FIN;
	assign mem_addr = MEM_AW'(idx * SPR_WORDS + word);

	// sizes in pixels
	assign x_len = 7'((r0_q[F_SZ_MSB:F_SZ_LSB] + 4'd1) * TILE_PX);
	assign y_len = 7'((r1_q[F_SZ_MSB:F_SZ_LSB] + 4'd1) * TILE_PX);

	// vertical hit test, one extra bit so Y + size does not wrap
	assign y_top = {1'b0, r1_q[F_CRD_MSB:0]};
	assign y_end = y_top + 10'(y_len);
	assign hit = r0_q[F_ACT] && ({1'b0, line} >= y_top) && ({1'b0, line} < y_end);
	assign y_ofs = 6'(line - r1_q[F_CRD_MSB:0]);
	assign last = r0_q[F_LEAP] || (idx == 6'(NUM_SPRITES - 1));

	assign job_xs = r0_q[F_SZ_MSB:F_SZ_LSB];
	assign job_xf = r0_q[F_FLIP];
	// flipped sprites start from their right edge, wrapping at 512
	assign job_x = r0_q[F_FLIP] ? r0_q[F_CRD_MSB:0] + 9'(x_len) - 9'd1 : r0_q[F_CRD_MSB:0];
	assign job_row = r1_q[F_FLIP] ? 6'(y_len - 7'd1) - y_ofs : y_ofs;
	assign job_tnum = r2_q[F_TNUM_MSB:0];
	assign job_pal = r2_q[MEM_DW-1:F_PAL_LSB];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state    <= SP_IDLE;
			word     <= R0;
			idx      <= '0;
			spr_next <= '0;
		end
		else
		begin
			case (state)
				SP_IDLE:
					if (spr_go)
					begin
						idx  <= spr_first;
						word <= R0;
						// table already exhausted on an earlier layer
						if (spr_first >= 6'(NUM_SPRITES))
						begin
							spr_next <= spr_first;
							state    <= SP_FIN;
						end
						else
							state <= SP_MREQ;
					end
				SP_MREQ:
					if (mem_ack)
						state <= SP_MREL;
				SP_MREL:
					if (!mem_ack)
					begin
						case (word)
							R0:
							begin
								word  <= R1;
								state <= SP_MREQ;
							end
							R1:
							begin
								// misses skip the R2 read
								word  <= R2;
								state <= hit ? SP_MREQ : SP_NEXT;
							end
							default:
								state <= SP_JOB;
						endcase
					end
				SP_JOB:
					if (job_done)
						state <= SP_JREL;
				SP_JREL:
					if (!job_done)
						state <= SP_NEXT;
				SP_NEXT:
					if (last)
					begin
						spr_next <= idx + 6'd1;
						state    <= SP_FIN;
					end
					else
					begin
						idx   <= idx + 6'd1;
						word  <= R0;
						state <= SP_MREQ;
					end
				SP_FIN:
					if (!spr_go)
						state <= SP_IDLE;
				default:
					state <= SP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == SP_MREQ && mem_ack)
		begin
			case (word)
				R0: r0_q <= mem_rdata;
				R1: r1_q <= mem_rdata;
				default: r2_q <= mem_rdata;
			endcase
		end
	end

	// sequencer only starts a sprite layer once the last job is retired
	a_go_no_job: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(spr_go) |-> !job_req);

endmodule

`default_nettype wire

// ==== rtl/ts_tile_scan.sv ====
// tile layer scanner, reads one row of tile-map words and sends one job per tile
`default_nettype none
`timescale 1ns/100ps

module ts_tile_scan import ts_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [8:0]        line,
	input  logic [5:0]        num_tiles,
	input  logic              tile_go,
	input  logic              tile_layer,
	output logic              tile_fin,
	output logic              mem_req,
	input  logic              mem_ack,
	output logic [MEM_AW-1:0] mem_addr,
	input  logic [MEM_DW-1:0] mem_rdata,
	output logic              job_req,
	input  logic              job_done,
	output logic [8:0]        job_x,
	output logic [2:0]        job_xs,
	output logic              job_xf,
	output logic [11:0]       job_tnum,
	output logic [5:0]        job_row,
	output logic [3:0]        job_pal
);

	typedef enum logic [2:0] {TL_IDLE, TL_MREQ, TL_MREL, TL_JOB, TL_JREL, TL_FIN} tl_state_e;

	tl_state_e         state;
	logic              layer_q;
	logic [5:0]        idx;
	logic [5:0]        count;
	logic [MEM_DW-1:0] word_q;

	assign mem_req = state == TL_MREQ;
	assign job_req = state == TL_JOB;
	assign tile_fin = state == TL_FIN;
	assign mem_addr = MEM_AW'(TMAP_BASE + TMAP_WORDS * layer_q + idx);

	assign job_x = 9'(idx * TILE_PX);
	assign job_xs = '0;
	assign job_xf = 1'b0;
	assign job_row = 6'(line % TILE_PX);
	assign job_tnum = word_q[F_TNUM_MSB:0];
	assign job_pal = word_q[MEM_DW-1:F_PAL_LSB];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state   <= TL_IDLE;
			layer_q <= 1'b0;
			idx     <= '0;
			count   <= '0;
		end
		else
		begin
			case (state)
				TL_IDLE:
					if (tile_go)
					begin
						layer_q <= tile_layer;
						idx     <= '0;
						count   <= (num_tiles > 6'(MAX_TILES)) ? 6'(MAX_TILES) : num_tiles;
						state   <= (num_tiles == '0) ? TL_FIN : TL_MREQ;
					end
				TL_MREQ:
					if (mem_ack)
						state <= TL_MREL;
				TL_MREL:
					if (!mem_ack)
						state <= TL_JOB;
				TL_JOB:
					if (job_done)
						state <= TL_JREL;
				TL_JREL:
					if (!job_done)
					begin
						if (idx == count - 6'd1)
							state <= TL_FIN;
						else
						begin
							idx   <= idx + 6'd1;
							state <= TL_MREQ;
						end
					end
				TL_FIN:
					if (!tile_go)
						state <= TL_IDLE;
				default:
					state <= TL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == TL_MREQ && mem_ack)
			word_q <= mem_rdata;
	end

endmodule

`default_nettype wire

// ==== rtl/ts_top.sv ====
// scanner top level, connects the layer sequencer, both scanners, the arbiter and the RAM
`default_nettype none
`timescale 1ns/100ps

module ts_top import ts_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  logic [8:0]        line,
	input  logic [7:0]        ts_conf,
	input  logic [5:0]        num_tiles,
	output logic              ts_busy,
	input  logic              cpu_req,
	output logic              cpu_ack,
	input  logic [MEM_AW-1:0] cpu_addr,
	input  logic [MEM_DW-1:0] cpu_wdata,
	output logic              tsr_go,
	input  logic              tsr_done,
	output logic [8:0]        tsr_x,
	output logic [2:0]        tsr_xs,
	output logic              tsr_xf,
	output logic [11:0]       tsr_tnum,
	output logic [5:0]        tsr_row,
	output logic [3:0]        tsr_pal
);

	// sequencer to scanner commands
	logic              spr_go, spr_fin, tile_go, tile_layer, tile_fin;
	logic [5:0]        spr_first, spr_next;

	// scanner memory ports
	logic              spr_mem_req, spr_mem_ack, tile_mem_req, tile_mem_ack;
	logic [MEM_AW-1:0] spr_mem_addr, tile_mem_addr, mem_addr;
	logic [MEM_DW-1:0] spr_mem_rdata, tile_mem_rdata, mem_wdata, mem_rdata;
	logic              mem_we;

	// scanner jobs
	logic              spr_job_req, spr_job_done, spr_job_xf;
	logic              tile_job_req, tile_job_done, tile_job_xf;
	logic [8:0]        spr_job_x, tile_job_x;
	logic [2:0]        spr_job_xs, tile_job_xs;
	logic [11:0]       spr_job_tnum, tile_job_tnum;
	logic [5:0]        spr_job_row, tile_job_row;
	logic [3:0]        spr_job_pal, tile_job_pal;

	ts_layer_seq u_seq (
		.clk, .rst_n, .start, .ts_conf, .ts_busy,
		.spr_go, .spr_first, .spr_fin, .spr_next,
		.tile_go, .tile_layer, .tile_fin,
		.spr_job_req, .spr_job_done, .spr_job_x, .spr_job_xs, .spr_job_xf,
		.spr_job_tnum, .spr_job_row, .spr_job_pal,
		.tile_job_req, .tile_job_done, .tile_job_x, .tile_job_xs, .tile_job_xf,
		.tile_job_tnum, .tile_job_row, .tile_job_pal,
		.tsr_go, .tsr_done, .tsr_x, .tsr_xs, .tsr_xf, .tsr_tnum, .tsr_row, .tsr_pal
	);

	ts_sprite_scan u_spr (
		.clk, .rst_n, .line, .spr_go, .spr_first, .spr_fin, .spr_next,
		.mem_req(spr_mem_req), .mem_ack(spr_mem_ack),
		.mem_addr(spr_mem_addr), .mem_rdata(spr_mem_rdata),
		.job_req(spr_job_req), .job_done(spr_job_done), .job_x(spr_job_x),
		.job_xs(spr_job_xs), .job_xf(spr_job_xf), .job_tnum(spr_job_tnum),
		.job_row(spr_job_row), .job_pal(spr_job_pal)
	);

	ts_tile_scan u_tile (
		.clk, .rst_n, .line, .num_tiles, .tile_go, .tile_layer, .tile_fin,
		.mem_req(tile_mem_req), .mem_ack(tile_mem_ack),
		.mem_addr(tile_mem_addr), .mem_rdata(tile_mem_rdata),
		.job_req(tile_job_req), .job_done(tile_job_done), .job_x(tile_job_x),
		.job_xs(tile_job_xs), .job_xf(tile_job_xf), .job_tnum(tile_job_tnum),
		.job_row(tile_job_row), .job_pal(tile_job_pal)
	);

	ts_mem_arb u_arb (
		.clk, .rst_n, .cpu_req, .cpu_ack, .cpu_addr, .cpu_wdata,
		.spr_req(spr_mem_req), .spr_ack(spr_mem_ack),
		.spr_addr(spr_mem_addr), .spr_rdata(spr_mem_rdata),
		.tile_req(tile_mem_req), .tile_ack(tile_mem_ack),
		.tile_addr(tile_mem_addr), .tile_rdata(tile_mem_rdata),
		.mem_we, .mem_addr, .mem_wdata, .mem_rdata
	);

	ts_mem u_mem (
		.clk, .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// ==== verif/ts_tb.sv ====
// testbench for ts_top, loads the RAM over the CPU port and checks render jobs per line case
`default_nettype none
`timescale 1ns/100ps

module ts_tb;

	localparam int NCASE = 12;
	localparam int MAXJ = 96;
	localparam int HS_TIMEOUT = 1000;
	localparam int LINE_TIMEOUT = 20000;

	logic        clk;
	logic        rst_n;
	logic        start;
	logic [8:0]  line;
	logic [7:0]  ts_conf;
	logic [5:0]  num_tiles;
	logic        ts_busy;
	logic        cpu_req;
	logic        cpu_ack;
	logic [7:0]  cpu_addr;
	logic [15:0] cpu_wdata;
	logic        tsr_go;
	logic        tsr_done;
	logic [8:0]  tsr_x;
	logic [2:0]  tsr_xs;
	logic        tsr_xf;
	logic [11:0] tsr_tnum;
	logic [5:0]  tsr_row;
	logic [3:0]  tsr_pal;

	integer seed = 59609;

	// line cases, jobs packed as {x, xs, xf, tnum, row, pal}
	string       t_name [NCASE];
	logic [7:0]  t_conf [NCASE];
	logic [8:0]  t_line [NCASE];
	logic [5:0]  t_tiles [NCASE];
	logic        t_cont [NCASE];
	int          t_cnt [NCASE];
	logic [34:0] t_job [NCASE][MAXJ];
	int          nc = 0;

	logic [34:0] rx_q [$];

	ts_top u_dut (
		.clk, .rst_n, .start, .line, .ts_conf, .num_tiles, .ts_busy,
		.cpu_req, .cpu_ack, .cpu_addr, .cpu_wdata,
		.tsr_go, .tsr_done, .tsr_x, .tsr_xs, .tsr_xf, .tsr_tnum, .tsr_row, .tsr_pal
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// all driving and sampling happens 1 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic stop_run();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_val(input string name, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act)
		begin
			$display("Error: test %s, %s: expected 0x%0h, actual 0x%0h", name, what, exp, act);
			stop_run();
		end
	endtask

	// tile-map fill, every address bit shows up in tnum or pal
	function automatic logic [15:0] fill_word(input logic [7:0] a);
		return {a ^ 8'h5c, ~a};
	endfunction

	function automatic logic [15:0] spr_r0(input logic [8:0] x, input logic [2:0] xsz,
		input logic act, input logic leap, input logic xflip);
		return {xflip, leap, act, 1'b0, xsz, x};
	endfunction

	function automatic logic [15:0] spr_r1(input logic [8:0] y, input logic [2:0] ysz,
		input logic yflip);
		return {yflip, 3'b000, ysz, y};
	endfunction

	// sprites 0..3 in use, the rest inactive
	function automatic logic [15:0] mem_image(input logic [7:0] a);
		case (a)
			8'd0: return spr_r0(9'd20, 3'd1, 1'b1, 1'b0, 1'b0);
			8'd1: return spr_r1(9'd100, 3'd1, 1'b0);
			8'd2: return 16'h3012;
			// inactive but in range, ends S0
			8'd3: return spr_r0(9'd50, 3'd0, 1'b0, 1'b1, 1'b0);
			8'd4: return spr_r1(9'd100, 3'd1, 1'b0);
			8'd5: return 16'h1111;
			// X wraps past 511 when mirrored, ends S1
			8'd6: return spr_r0(9'd500, 3'd2, 1'b1, 1'b1, 1'b1);
			8'd7: return spr_r1(9'd100, 3'd0, 1'b1);
			8'd8: return 16'ha345;
			8'd9: return spr_r0(9'd200, 3'd0, 1'b1, 1'b0, 1'b0);
			8'd10: return spr_r1(9'd104, 3'd3, 1'b0);
			8'd11: return 16'h5abc;
			default: return (a >= 8'd128) ? fill_word(a) : 16'h0000;
		endcase
	endfunction

	task automatic cpu_write(input logic [7:0] addr, input logic [15:0] data);
		int n;
		cpu_addr = addr;
		cpu_wdata = data;
		cpu_req = 1'b1;
		n = 0;
		while (!cpu_ack)
		begin
			step();
			n++;
			if (n > HS_TIMEOUT)
			begin
				$display("timeout: CPU write to address %0d was never acknowledged", addr);
				stop_run();
			end
		end
		cpu_req = 1'b0;
		n = 0;
		while (cpu_ack)
		begin
			step();
			n++;
			if (n > HS_TIMEOUT)
			begin
				$display("timeout: CPU write ack did not drop");
				stop_run();
			end
		end
	endtask

	// writes to a tile-map word that no scan reads
	task automatic cpu_contend();
		int k;
		int gap;
		for (k = 0; k < 10; k++)
		begin
			gap = $random(seed) & 15;
			repeat (gap) step();
			cpu_write(8'd255, 16'(k * 4369));
		end
	endtask

	task automatic add_case(input string name, input logic [7:0] conf, input logic [8:0] ln,
		input logic [5:0] tiles, input logic cont);
		t_name[nc] = name;
		t_conf[nc] = conf;
		t_line[nc] = ln;
		t_tiles[nc] = tiles;
		t_cont[nc] = cont;
		t_cnt[nc] = 0;
		nc++;
	endtask

	task automatic add_job(input logic [8:0] x, input logic [2:0] xs, input logic xf,
		input logic [11:0] tnum, input logic [5:0] row, input logic [3:0] pal);
		t_job[nc - 1][t_cnt[nc - 1]] = {x, xs, xf, tnum, row, pal};
		t_cnt[nc - 1]++;
	endtask

	// one job per tile, x = 8 * i, row = line mod 8
	task automatic add_tiles(input int layer);
		int c;
		int i;
		logic [15:0] w;
		c = nc - 1;
		for (i = 0; i < int'(t_tiles[c]); i++)
		begin
			w = fill_word(8'(128 + 64 * layer + i));
			add_job(9'(8 * i), 3'd0, 1'b0, w[11:0], 6'(t_line[c] % 9'd8), w[15:12]);
		end
	endtask

	task automatic build_table();
		add_case("spr_above", 8'h80, 9'd99, 6'd0, 1'b0);
		add_case("spr_top", 8'h80, 9'd100, 6'd0, 1'b0);
		add_job(9'd20, 3'd1, 1'b0, 12'h012, 6'd0, 4'h3);
		add_job(9'd11, 3'd2, 1'b1, 12'h345, 6'd7, 4'ha);
		add_case("spr_yflip", 8'h80, 9'd107, 6'd0, 1'b0);
		add_job(9'd20, 3'd1, 1'b0, 12'h012, 6'd7, 4'h3);
		add_job(9'd11, 3'd2, 1'b1, 12'h345, 6'd0, 4'ha);
		add_job(9'd200, 3'd0, 1'b0, 12'habc, 6'd3, 4'h5);
		add_case("spr_last_row", 8'h80, 9'd115, 6'd0, 1'b0);
		add_job(9'd20, 3'd1, 1'b0, 12'h012, 6'd15, 4'h3);
		add_job(9'd200, 3'd0, 1'b0, 12'habc, 6'd11, 4'h5);
		add_case("spr_below", 8'h80, 9'd116, 6'd0, 1'b0);
		add_job(9'd200, 3'd0, 1'b0, 12'habc, 6'd12, 4'h5);
		add_case("spr_s2_last", 8'h80, 9'd135, 6'd0, 1'b0);
		add_job(9'd200, 3'd0, 1'b0, 12'habc, 6'd31, 4'h5);
		add_case("tile_l0", 8'h20, 9'd13, 6'd5, 1'b0);
		add_tiles(0);
		add_case("tile_l1", 8'h40, 9'd22, 6'd7, 1'b0);
		add_tiles(1);
		add_case("all_layers", 8'he0, 9'd107, 6'd3, 1'b0);
		add_job(9'd20, 3'd1, 1'b0, 12'h012, 6'd7, 4'h3);
		add_tiles(0);
		add_job(9'd11, 3'd2, 1'b1, 12'h345, 6'd0, 4'ha);
		add_tiles(1);
		add_job(9'd200, 3'd0, 1'b0, 12'habc, 6'd3, 4'h5);
		add_case("all_off", 8'h00, 9'd107, 6'd3, 1'b0);
		add_case("no_sprites", 8'h60, 9'd107, 6'd4, 1'b0);
		add_tiles(0);
		add_tiles(1);
		// sprite 2 misses this line, so S1 sends nothing
		add_case("contention", 8'he0, 9'd115, 6'd45, 1'b1);
		add_job(9'd20, 3'd1, 1'b0, 12'h012, 6'd15, 4'h3);
		add_tiles(0);
		add_tiles(1);
		add_job(9'd200, 3'd0, 1'b0, 12'habc, 6'd11, 4'h5);
	endtask

	task automatic wait_line_done(input int c);
		int n;
		n = 0;
		while (ts_busy)
		begin
			step();
			n++;
			if (n > LINE_TIMEOUT)
			begin
				$display("timeout: ts_busy never fell in test %s", t_name[c]);
				stop_run();
			end
		end
	endtask

	task automatic check_jobs(input int c);
		int j;
		logic [34:0] e;
		logic [34:0] a;
		check_val(t_name[c], "job count", 32'(t_cnt[c]), 32'(rx_q.size()));
		for (j = 0; j < t_cnt[c]; j++)
		begin
			e = t_job[c][j];
			a = rx_q[j];
			check_val(t_name[c], $sformatf("job %0d x", j), 32'(e[34:26]), 32'(a[34:26]));
			check_val(t_name[c], $sformatf("job %0d xs", j), 32'(e[25:23]), 32'(a[25:23]));
			check_val(t_name[c], $sformatf("job %0d xf", j), 32'(e[22]), 32'(a[22]));
			check_val(t_name[c], $sformatf("job %0d tnum", j), 32'(e[21:10]), 32'(a[21:10]));
			check_val(t_name[c], $sformatf("job %0d row", j), 32'(e[9:4]), 32'(a[9:4]));
			check_val(t_name[c], $sformatf("job %0d pal", j), 32'(e[3:0]), 32'(a[3:0]));
		end
	endtask

	// renderer model, answers each job after 0 to 7 cycles
	initial
	begin
		int delay;
		int n;
		tsr_done = 1'b0;
		forever
		begin
			step();
			if (rst_n && tsr_go && !tsr_done)
			begin
				rx_q.push_back({tsr_x, tsr_xs, tsr_xf, tsr_tnum, tsr_row, tsr_pal});
				delay = $random(seed) & 7;
				repeat (delay) step();
				tsr_done = 1'b1;
				n = 0;
				while (tsr_go)
				begin
					step();
					n++;
					if (n > HS_TIMEOUT)
					begin
						$display("timeout: tsr_go stayed high after tsr_done");
						stop_run();
					end
				end
				tsr_done = 1'b0;
			end
		end
	end

	initial
	begin
		int a;
		int c;
		rst_n = 1'b0;
		start = 1'b0;
		line = '0;
		ts_conf = '0;
		num_tiles = '0;
		cpu_req = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		repeat (3) step();
		rst_n = 1'b1;
		step();

		for (a = 0; a < 256; a++)
			cpu_write(8'(a), mem_image(8'(a)));
		build_table();

		for (c = 0; c < nc; c++)
		begin
			ts_conf = t_conf[c];
			line = t_line[c];
			num_tiles = t_tiles[c];
			rx_q.delete();
			step();
			start = 1'b1;
			step();
			start = 1'b0;
			check_val(t_name[c], "ts_busy after start", 32'd1, 32'(ts_busy));
			if (t_cont[c])
			begin
				fork
					wait_line_done(c);
					cpu_contend();
				join
			end
			else
				wait_line_done(c);
			check_jobs(c);
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire
